/* logic/bus_pkg.sv */
// Bus structs for the OBI slave port and the internal register bus
// Both buses use 32-bit addresses and data
`default_nettype none

package bus_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef struct packed {
    logic                req;
    logic                we;
    logic [BE_WIDTH-1:0] be;
    addr_t               addr;
    data_t               wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } obi_rsp_t;

  // Single-cycle register access, answered in the same cycle
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

endpackage

`default_nettype wire

/* logic/periph_pkg.sv */
// Address map of the subsystem: three 256-byte windows, the rest unmapped
// Register offsets are byte offsets inside a window, one word each
`default_nettype none

package periph_pkg;

  localparam int unsigned PERIPHERALS      = 3;
  localparam int unsigned GPIO_IDX         = 0;
  localparam int unsigned TIMER_IDX        = 1;
  localparam int unsigned IRQ_IDX          = 2;
  localparam int unsigned PERIPH_SEL_WIDTH = 2;
  localparam int unsigned WINDOW_BITS      = 8;

  typedef logic [PERIPH_SEL_WIDTH-1:0] periph_sel_t;
  typedef logic [WINDOW_BITS-1:0] offset_t;

  localparam logic [31:0] GPIO_BASE  = 32'h0000_0000;
  localparam logic [31:0] TIMER_BASE = 32'h0000_0100;
  localparam logic [31:0] IRQ_BASE   = 32'h0000_0200;

  // Indexed by GPIO_IDX, TIMER_IDX and IRQ_IDX
  localparam logic [PERIPHERALS-1:0][31:0] PERIPH_BASE = {IRQ_BASE, TIMER_BASE, GPIO_BASE};

  localparam offset_t GPIO_DIR = 8'h00, GPIO_OUT = 8'h04, GPIO_IN = 8'h08;
  localparam offset_t GPIO_INTR_EN = 8'h0C, GPIO_INTR_STATUS = 8'h10;
  localparam offset_t TMR_CTRL = 8'h00, TMR_COUNT = 8'h04;
  localparam offset_t TMR_COMPARE = 8'h08, TMR_STATUS = 8'h0C;
  localparam offset_t IRQ_PENDING = 8'h00, IRQ_ENABLE = 8'h04;
  localparam offset_t IRQ_CLAIM = 8'h08, IRQ_MSIP = 8'h0C;

  // Source 0 is reserved and always reads zero
  localparam int unsigned IRQ_SRC_GPIO  = 1;
  localparam int unsigned IRQ_SRC_TIMER = 2;
  localparam int unsigned IRQ_USED_NINT = 3;

endpackage

`default_nettype wire

/* logic/obi_to_reg.sv */
// OBI slave to register bus bridge with one access per cycle and no read back-pressure
// Byte enables are ignored, so every write updates a whole word
`timescale 1ns/1ns
`default_nettype none

module obi_to_reg (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  bus_pkg::obi_req_t obi_req_i,
  output bus_pkg::obi_rsp_t obi_rsp_o,
  output bus_pkg::reg_req_t reg_req_o,
  input  bus_pkg::reg_rsp_t reg_rsp_i
);

  logic           accept;
  logic           rvalid_q;
  logic           err_q;
  bus_pkg::data_t rdata_q;

  always_comb begin
    reg_req_o.valid = obi_req_i.req;
    reg_req_o.write = obi_req_i.we;
    reg_req_o.addr  = obi_req_i.addr;
    reg_req_o.wdata = obi_req_i.wdata;
  end

  assign accept = obi_req_i.req & reg_rsp_i.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= accept;
      err_q    <= accept & reg_rsp_i.error;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (accept) begin
      rdata_q <= obi_req_i.we ? '0 : reg_rsp_i.rdata;
    end
  end

  always_comb begin
    obi_rsp_o.gnt    = accept;
    obi_rsp_o.rvalid = rvalid_q;
    obi_rsp_o.err    = err_q;
    obi_rsp_o.rdata  = rdata_q;
  end

endmodule

`default_nettype wire

/* logic/reg_demux.sv */
// Routes a register access to the peripheral whose window holds the address
// Unmapped addresses get ready, error and zero data from here
`timescale 1ns/1ns
`default_nettype none

module reg_demux (
  input  bus_pkg::reg_req_t                               reg_req_i,
  output bus_pkg::reg_rsp_t                               reg_rsp_o,
  output bus_pkg::reg_req_t [periph_pkg::PERIPHERALS-1:0] out_req_o,
  input  bus_pkg::reg_rsp_t [periph_pkg::PERIPHERALS-1:0] out_rsp_i
);

  localparam int unsigned AW = bus_pkg::ADDR_WIDTH;
  localparam int unsigned WB = periph_pkg::WINDOW_BITS;

  periph_pkg::periph_sel_t sel;
  logic                    hit;

  // Window match on the upper address bits
  always_comb begin
    sel = '0;
    hit = 1'b0;
    for (int i = 0; i < periph_pkg::PERIPHERALS; i++) begin
      if (reg_req_i.addr[AW-1:WB] == periph_pkg::PERIPH_BASE[i][AW-1:WB]) begin
        sel = periph_pkg::periph_sel_t'(i);
        hit = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < periph_pkg::PERIPHERALS; i++) begin
      out_req_o[i]       = reg_req_i;
      out_req_o[i].valid = reg_req_i.valid & hit & (sel == periph_pkg::periph_sel_t'(i));
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b1;
    reg_rsp_o.rdata = '0;
    for (int i = 0; i < periph_pkg::PERIPHERALS; i++) begin
      if (hit && (sel == periph_pkg::periph_sel_t'(i))) begin
        reg_rsp_o = out_rsp_i[i];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/gpio_regs.sv */
// GPIO bank, GPIO_WIDTH pins up to 32, inputs pass a two-flop synchronizer
// Any rising edge sets status; the enable register only masks the interrupt
`timescale 1ns/1ns
`default_nettype none

module gpio_regs #(
  parameter int unsigned GPIO_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  bus_pkg::reg_req_t     reg_req_i,
  output bus_pkg::reg_rsp_t     reg_rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_en_o,
  output logic                  gpio_intr_o
);

  logic                  wr;
  periph_pkg::offset_t   offset;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] intr_en_q;
  logic [GPIO_WIDTH-1:0] status_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] prev_q;
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] wdata;

  assign wr     = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[periph_pkg::WINDOW_BITS-1:0];
  assign wdata  = reg_req_i.wdata[GPIO_WIDTH-1:0];
  assign rise   = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q     <= '0;
      out_q     <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && offset == periph_pkg::GPIO_DIR) dir_q <= wdata;
      if (wr && offset == periph_pkg::GPIO_OUT) out_q <= wdata;
      if (wr && offset == periph_pkg::GPIO_INTR_EN) intr_en_q <= wdata;
      // A new edge wins over a clear in the same cycle
      if (wr && offset == periph_pkg::GPIO_INTR_STATUS) begin
        status_q <= (status_q & ~wdata) | rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::GPIO_DIR:         reg_rsp_o.rdata = bus_pkg::data_t'(dir_q);
      periph_pkg::GPIO_OUT:         reg_rsp_o.rdata = bus_pkg::data_t'(out_q);
      periph_pkg::GPIO_IN:          reg_rsp_o.rdata = bus_pkg::data_t'(sync2_q);
      periph_pkg::GPIO_INTR_EN:     reg_rsp_o.rdata = bus_pkg::data_t'(intr_en_q);
      periph_pkg::GPIO_INTR_STATUS: reg_rsp_o.rdata = bus_pkg::data_t'(status_q);
      default:                      reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = dir_q;
  assign gpio_intr_o = |(status_q & intr_en_q);

endmodule

`default_nettype wire

/* logic/timer_regs.sv */
// 32-bit compare timer, counts one per clock while enabled and wraps silently
// Expiry is only seen while the counter runs
`timescale 1ns/1ns
`default_nettype none

module timer_regs (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  bus_pkg::reg_req_t reg_req_i,
  output bus_pkg::reg_rsp_t reg_rsp_o,
  output logic              timer_intr_o
);

  logic                wr;
  periph_pkg::offset_t offset;
  logic                enable_q;
  bus_pkg::data_t      count_q;
  bus_pkg::data_t      compare_q;
  logic                status_q;
  logic                expired;

  assign wr      = reg_req_i.valid & reg_req_i.write;
  assign offset  = reg_req_i.addr[periph_pkg::WINDOW_BITS-1:0];
  assign expired = enable_q & (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      status_q  <= 1'b0;
    end else begin
      if (wr && offset == periph_pkg::TMR_CTRL) enable_q <= reg_req_i.wdata[0];
      if (wr && offset == periph_pkg::TMR_COMPARE) compare_q <= reg_req_i.wdata;
      // Software load has priority over counting
      if (wr && offset == periph_pkg::TMR_COUNT) begin
        count_q <= reg_req_i.wdata;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (expired) begin
        status_q <= 1'b1;
      end else if (wr && offset == periph_pkg::TMR_STATUS && reg_req_i.wdata[0]) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::TMR_CTRL:    reg_rsp_o.rdata = bus_pkg::data_t'(enable_q);
      periph_pkg::TMR_COUNT:   reg_rsp_o.rdata = count_q;
      periph_pkg::TMR_COMPARE: reg_rsp_o.rdata = compare_q;
      periph_pkg::TMR_STATUS:  reg_rsp_o.rdata = bus_pkg::data_t'(status_q);
      default:                 reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_intr_o = status_q;

endmodule

`default_nettype wire

/* logic/irq_ctrl.sv */
// Level-sensitive interrupt controller without priorities or thresholds
// NUM_EXT_IRQ from 1 to 29, so all sources fit one 32-bit register
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl #(
  parameter int unsigned NUM_EXT_IRQ = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  bus_pkg::reg_req_t      reg_req_i,
  output bus_pkg::reg_rsp_t      reg_rsp_o,
  input  logic                   gpio_intr_i,
  input  logic                   timer_intr_i,
  input  logic [NUM_EXT_IRQ-1:0] irq_ext_i,
  output logic                   irq_o,
  output logic                   msip_o
);

  localparam int unsigned NUM_SRC  = periph_pkg::IRQ_USED_NINT + NUM_EXT_IRQ;
  localparam int unsigned ID_WIDTH = $clog2(NUM_SRC);

  logic                wr;
  periph_pkg::offset_t offset;
  logic [NUM_SRC-1:0]  src;
  logic [NUM_SRC-1:0]  pending_q;
  logic [NUM_SRC-1:0]  enable_q;
  logic [NUM_SRC-1:0]  active;
  logic [ID_WIDTH-1:0] claim_id;
  logic                msip_q;
  logic                irq_q;

  assign wr     = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[periph_pkg::WINDOW_BITS-1:0];
  assign active = pending_q & enable_q;

  // Source 0 stays tied low
  always_comb begin
    src = '0;
    src[periph_pkg::IRQ_SRC_GPIO]  = gpio_intr_i;
    src[periph_pkg::IRQ_SRC_TIMER] = timer_intr_i;
    src[NUM_SRC-1:periph_pkg::IRQ_USED_NINT] = irq_ext_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      pending_q <= src;
      irq_q     <= |active;
      if (wr && offset == periph_pkg::IRQ_ENABLE) enable_q <= reg_req_i.wdata[NUM_SRC-1:0];
      if (wr && offset == periph_pkg::IRQ_MSIP) msip_q <= reg_req_i.wdata[0];
    end
  end

  // Lowest active source wins, 0 when nothing is active
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = ID_WIDTH'(i);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::IRQ_PENDING: reg_rsp_o.rdata = bus_pkg::data_t'(pending_q);
      periph_pkg::IRQ_ENABLE:  reg_rsp_o.rdata = bus_pkg::data_t'(enable_q);
      periph_pkg::IRQ_CLAIM:   reg_rsp_o.rdata = bus_pkg::data_t'(claim_id);
      periph_pkg::IRQ_MSIP:    reg_rsp_o.rdata = bus_pkg::data_t'(msip_q);
      default:                 reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule

`default_nettype wire

/* logic/peripheral_subsystem.sv */
// Peripheral subsystem: OBI slave port, GPIO bank, compare timer, interrupt controller
// Single clock domain; gpio_i and irq_ext_i are sampled on clk_i
`timescale 1ns/1ns
`default_nettype none

module peripheral_subsystem #(
  parameter int unsigned NUM_EXT_IRQ = 4,
  parameter int unsigned GPIO_WIDTH  = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  bus_pkg::obi_req_t      obi_req_i,
  output bus_pkg::obi_rsp_t      obi_rsp_o,
  input  logic [GPIO_WIDTH-1:0]  gpio_i,
  output logic [GPIO_WIDTH-1:0]  gpio_o,
  output logic [GPIO_WIDTH-1:0]  gpio_en_o,
  input  logic [NUM_EXT_IRQ-1:0] irq_ext_i,
  output logic                   irq_o,
  output logic                   msip_o,
  output logic                   timer_intr_o
);

  bus_pkg::reg_req_t                               bridge_req;
  bus_pkg::reg_rsp_t                               bridge_rsp;
  bus_pkg::reg_req_t [periph_pkg::PERIPHERALS-1:0] periph_req;
  bus_pkg::reg_rsp_t [periph_pkg::PERIPHERALS-1:0] periph_rsp;
  logic                                            gpio_intr;

  obi_to_reg obi_to_reg_inst (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_rsp_o,
    .reg_req_o(bridge_req),
    .reg_rsp_i(bridge_rsp)
  );

  reg_demux reg_demux_inst (
    .reg_req_i(bridge_req),
    .reg_rsp_o(bridge_rsp),
    .out_req_o(periph_req),
    .out_rsp_i(periph_rsp)
  );

  gpio_regs #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio_regs_inst (
    .clk_i,
    .rst_n_i,
    .reg_req_i  (periph_req[periph_pkg::GPIO_IDX]),
    .reg_rsp_o  (periph_rsp[periph_pkg::GPIO_IDX]),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .gpio_intr_o(gpio_intr)
  );

  timer_regs timer_regs_inst (
    .clk_i,
    .rst_n_i,
    .reg_req_i(periph_req[periph_pkg::TIMER_IDX]),
    .reg_rsp_o(periph_rsp[periph_pkg::TIMER_IDX]),
    .timer_intr_o
  );

  // Timer line also feeds the interrupt controller
  irq_ctrl #(
    .NUM_EXT_IRQ(NUM_EXT_IRQ)
  ) irq_ctrl_inst (
    .clk_i,
    .rst_n_i,
    .reg_req_i   (periph_req[periph_pkg::IRQ_IDX]),
    .reg_rsp_o   (periph_rsp[periph_pkg::IRQ_IDX]),
    .gpio_intr_i (gpio_intr),
    .timer_intr_i(timer_intr_o),
    .irq_ext_i,
    .irq_o,
    .msip_o
  );

endmodule

`default_nettype wire

/* tb/peripheral_subsystem_properties.sv */
// Bound into peripheral_subsystem, expects a response exactly one cycle after each grant
`timescale 1ns/1ns
`default_nettype none

module peripheral_subsystem_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic irq_i
);

  int unsigned fail_count = 0;

  rvalid_after_grant: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) gnt_i |=> rvalid_i
  ) else begin
    $error("rvalid missing one cycle after a grant");
    fail_count++;
  end

  rvalid_needs_grant: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_i |-> $past(gnt_i)
  ) else begin
    $error("rvalid without a grant in the cycle before");
    fail_count++;
  end

  // Outputs settle to zero one edge into reset
  quiet_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |=> (!rvalid_i && !irq_i)
  ) else begin
    $error("rvalid or irq_o high during reset");
    fail_count++;
  end

endmodule

`default_nettype wire

/* tb/tb_peripheral_subsystem.sv */
// Runs the operations listed in tb/testdata_peripheral.txt relative to the project root
// Uses the default DUT parameters with 8 GPIO pins and 4 external interrupt lines
`timescale 1ns/1ns
`default_nettype none

module tb_peripheral_subsystem;

  localparam int unsigned CLK_PERIOD   = 40;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned MAX_LINES    = 64;
  localparam int unsigned LINE_CYCLES  = 20;
  localparam int unsigned GRANT_LIMIT  = 16;

  logic              clk = 1'b0;
  logic              rst_n;
  bus_pkg::obi_req_t obi_req;
  bus_pkg::obi_rsp_t obi_rsp;
  logic [7:0]        gpio_in;
  logic [7:0]        gpio_out;
  logic [7:0]        gpio_en;
  logic [3:0]        irq_ext;
  logic              irq;
  logic              msip;
  logic              timer_intr;
  logic [31:0]       testdata [4*MAX_LINES];
  int unsigned       num_lines;
  logic              loaded;

  always #(CLK_PERIOD / 2) clk = ~clk;

  peripheral_subsystem peripheral_subsystem_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .obi_req_i   (obi_req),
    .obi_rsp_o   (obi_rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_en_o   (gpio_en),
    .irq_ext_i   (irq_ext),
    .irq_o       (irq),
    .msip_o      (msip),
    .timer_intr_o(timer_intr)
  );

  bind peripheral_subsystem peripheral_subsystem_properties properties_inst (
    .clk_i,
    .rst_n_i,
    .gnt_i   (obi_rsp_o.gnt),
    .rvalid_i(obi_rsp_o.rvalid),
    .irq_i   (irq_o)
  );

  // Columns are opcode, address or value, write data or read error, expected value
  function automatic logic [31:0] data_field(input int unsigned line, input int unsigned col);
    return testdata[4*line + col];
  endfunction

  function automatic logic [31:0] expected_err(input int unsigned line);
    return (data_field(line, 0) == 32'h1) ? 32'h0 : data_field(line, 2);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic drive_line(input int unsigned line);
    bus_pkg::obi_req_t req;
    req       = '0;
    req.req   = 1'b1;
    req.we    = (data_field(line, 0) == 32'h1);
    req.be    = '1;
    req.addr  = data_field(line, 1);
    req.wdata = req.we ? data_field(line, 2) : '0;
    obi_req <= req;
  endtask

  // Requests go out every cycle; each response is due one cycle after its grant
  task automatic bus_sequence(input int unsigned first, input int unsigned count);
    int unsigned issued;
    int unsigned returned;
    int unsigned stalls;
    logic        granted;
    issued   = 0;
    returned = 0;
    stalls   = 0;
    granted  = 1'b0;
    @(posedge clk);
    drive_line(first);
    while (returned < count) begin
      @(posedge clk);
      if (granted) begin
        check_value("obi_rsp_o.rvalid", 32'(obi_rsp.rvalid), 32'h1);
        check_value("obi_rsp_o.err", 32'(obi_rsp.err), expected_err(first + returned));
        check_value("obi_rsp_o.rdata", obi_rsp.rdata, data_field(first + returned, 3));
        returned++;
      end
      granted = 1'b0;
      if (issued < count) begin
        if (obi_rsp.gnt) begin
          granted = 1'b1;
          issued++;
          if (issued < count) begin
            drive_line(first + issued);
          end else begin
            obi_req <= '0;
          end
        end else begin
          stalls++;
          if (stalls > GRANT_LIMIT) abort_run("No grant from the DUT for a bus request");
        end
      end
    end
  endtask

  task automatic check_output(input logic [31:0] sel, input logic [31:0] expected);
    case (sel)
      32'h0:   check_value("irq_o", 32'(irq), expected);
      32'h1:   check_value("msip_o", 32'(msip), expected);
      32'h2:   check_value("timer_intr_o", 32'(timer_intr), expected);
      32'h3:   check_value("gpio_o", 32'(gpio_out), expected);
      32'h4:   check_value("gpio_en_o", 32'(gpio_en), expected);
      default: abort_run("Data file selects an unknown output to check");
    endcase
  endtask

  initial begin
    wait (loaded);
    #(num_lines * LINE_CYCLES * CLK_PERIOD);
    abort_run("Run timed out before the last data line was done");
  end

  initial begin
    int unsigned line;
    int unsigned step;
    obi_req   = '0;
    gpio_in   = '0;
    irq_ext   = '0;
    rst_n     = 1'b0;
    loaded    = 1'b0;
    num_lines = 0;
    $readmemh("tb/testdata_peripheral.txt", testdata);
    while (num_lines < MAX_LINES && testdata[4*num_lines] !== 32'hf) num_lines++;
    if (num_lines == MAX_LINES) abort_run("Data file is missing or has no end marker");
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // Outputs leave reset low
    @(posedge clk);
    for (int sel = 0; sel < 5; sel++) begin
      check_output(32'(sel), 32'h0);
    end
    line = 0;
    while (line < num_lines) begin
      step = 1;
      case (data_field(line, 0))
        32'h1, 32'h2: bus_sequence(line, 1);
        32'h7: begin
          while (line + step < num_lines && data_field(line + step, 0) == 32'h7) step++;
          bus_sequence(line, step);
        end
        32'h3: begin
          @(posedge clk);
          gpio_in <= 8'(data_field(line, 1));
        end
        32'h4: begin
          @(posedge clk);
          irq_ext <= 4'(data_field(line, 1));
        end
        32'h5: repeat (data_field(line, 1)) @(posedge clk);
        32'h6: begin
          @(posedge clk);
          check_output(data_field(line, 1), data_field(line, 3));
        end
        default: abort_run($sformatf("Unknown opcode on data line %0d", line));
      endcase
      line += step;
    end
    @(posedge clk);
    if (peripheral_subsystem_inst.properties_inst.fail_count != 0) begin
      $display("Bound bus assertions failed during the run");
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb/testdata_peripheral.txt */
// opcode addr/value wdata/err expected; 1 write, 2 read, 7 back-to-back read
// 3 set gpio_i, 4 set irq_ext_i, 5 wait cycles, 6 check output (0 irq 1 msip 2 timer 3 gpio_o 4 gpio_en), f end
1 000 000000a5 00000000
1 004 0000003c 00000000
6 004 00000000 000000a5
6 003 00000000 0000003c
1 108 00000014 00000000
1 00c 000000ff 00000000
1 204 0000000e 00000000
3 05a 00000000 00000000
5 004 00000000 00000000
2 008 00000000 0000005a
2 010 00000000 0000005a
6 000 00000000 00000001
2 200 00000000 00000002
4 001 00000000 00000000
5 002 00000000 00000000
1 204 00000008 00000000
2 208 00000000 00000003
1 204 00000000 00000000
2 208 00000000 00000000
6 000 00000000 00000000
1 010 0000005a 00000000
2 010 00000000 00000000
1 204 00000004 00000000
1 100 00000001 00000000
5 028 00000000 00000000
2 10c 00000000 00000001
6 002 00000000 00000001
6 000 00000000 00000001
1 10c 00000001 00000000
6 002 00000000 00000000
1 20c 00000001 00000000
6 001 00000000 00000001
1 20c 00000000 00000000
6 001 00000000 00000000
7 000 00000000 000000a5
7 004 00000000 0000003c
7 108 00000000 00000014
7 204 00000000 00000004
7 300 00000001 00000000
7 20c 00000000 00000000
f 000 00000000 00000000

/* files.f */
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/obi_to_reg.sv
logic/reg_demux.sv
logic/gpio_regs.sv
logic/timer_regs.sv
logic/irq_ctrl.sv
logic/peripheral_subsystem.sv
tb/peripheral_subsystem_properties.sv
tb/tb_peripheral_subsystem.sv
